/* mcu_macros.svh */
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

//////////////////////////////////////////////////
// timing constants of the MCU command front end
//////////////////////////////////////////////////

// frequency measurement window in clk cycles, short for simulation
`define MCU_FREQ_GATE_CYCLES 1000

// flops in each pin synchronizer (sck, mosi, cs_n, sysclk)
`define MCU_SYNC_STAGES 2

// low time of mcu_read / mcu_write in clk cycles
`define MCU_PULSE_CYCLES 2

`endif

/* spi_frame_pkg.sv */
`default_nettype none

package spi_frame_pkg;

   //////////////////////////////////////////////////
   // positions inside an SPI frame
   //////////////////////////////////////////////////

   // bit position inside a byte, MSB arrives first
   typedef logic [2:0] bit_pos_t;

   // byte index inside a frame, saturates at 255
   // command byte is 1, first parameter is 2
   typedef logic [7:0] byte_idx_t;

endpackage

`default_nettype wire

/* mcu_cmd_pkg.sv */
`default_nettype none

package mcu_cmd_pkg;

   //////////////////////////////////////////////////
   // register types
   //////////////////////////////////////////////////

   typedef logic [23:0] sram_addr_t;
   typedef logic [10:0] dac_addr_t;
   typedef logic [23:0] mask_t;
   typedef logic [31:0] freq_t;

   //////////////////////////////////////////////////
   // command encoding
   //////////////////////////////////////////////////

   // upper nibble of the command byte
   typedef enum logic [3:0] {
      SET_ADDR  = 4'h0,
      ROM_MASK  = 4'h1,
      SRAM_MASK = 4'h2,
      MAPPER    = 4'h3,
      READ      = 4'h8,
      WRITE     = 4'h9,
      DAC_CTRL  = 4'hE,
      READBACK  = 4'hF
   } opcode_grp_e;

   // full command codes
   localparam logic [7:0] CMD_DAC_PAUSE = 8'hE1;
   localparam logic [7:0] CMD_DAC_PLAY  = 8'hE2;
   localparam logic [7:0] CMD_ID        = 8'hF0;
   localparam logic [7:0] CMD_FREQ      = 8'hFE;

   // answer to CMD_ID
   localparam logic [7:0] RESP_ECHO_ID = 8'hA5;

endpackage

`default_nettype wire

/* spi_byte_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module spi_byte_rx (
   input  wire logic              clk,
   input  wire logic              arst_n,
   input  wire logic              sck,
   input  wire logic              mosi,
   input  wire logic              cs_n,
   input  wire logic [7:0]        resp_byte,
   output logic                   miso,
   output logic                   frame_start,
   output logic                   byte_done,
   output logic [7:0]             rx_byte,
   output spi_frame_pkg::bit_pos_t bit_cnt
);

   logic [`MCU_SYNC_STAGES-1:0] sck_sync;
   logic [`MCU_SYNC_STAGES-1:0] mosi_sync;
   logic [`MCU_SYNC_STAGES-1:0] cs_sync;
   logic                        sck_s;
   logic                        mosi_s;
   logic                        cs_s;
   logic                        sck_d;
   logic                        cs_d;
   logic                        sck_rise;
   logic                        sck_fall;
   logic [7:0]                  tx_shift;
   logic                        load_pend;

   //////////////////////////////////////////////////
   // pin synchronizers and edge detect
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sck_sync  <= '0;
         mosi_sync <= '0;
         cs_sync   <= '1;
         sck_d     <= 1'b0;
         cs_d      <= 1'b1;
      end else begin
         sck_sync  <= {sck_sync[`MCU_SYNC_STAGES-2:0], sck};
         mosi_sync <= {mosi_sync[`MCU_SYNC_STAGES-2:0], mosi};
         cs_sync   <= {cs_sync[`MCU_SYNC_STAGES-2:0], cs_n};
         sck_d     <= sck_s;
         cs_d      <= cs_s;
      end
   end

   assign sck_s    = sck_sync[`MCU_SYNC_STAGES-1];
   assign mosi_s   = mosi_sync[`MCU_SYNC_STAGES-1];
   assign cs_s     = cs_sync[`MCU_SYNC_STAGES-1];
   assign sck_rise = sck_s & ~sck_d;
   assign sck_fall = ~sck_s & sck_d;

   //////////////////////////////////////////////////
   // receive side
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bit_cnt     <= '0;
         byte_done   <= 1'b0;
         frame_start <= 1'b0;
      end else begin
         frame_start <= cs_d & ~cs_s;
         byte_done   <= 1'b0;
         if (cs_s) begin
            bit_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt   <= bit_cnt + 3'd1;
            byte_done <= (bit_cnt == 3'd7);
         end
      end
   end

   // mode 0, data sampled on rising sck
   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_byte <= {rx_byte[6:0], mosi_s};
      end
   end

   //////////////////////////////////////////////////
   // response side
   //////////////////////////////////////////////////

   // new response byte goes out on the falling edge after byte_done
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_shift  <= '0;
         load_pend <= 1'b0;
      end else if (frame_start) begin
         tx_shift  <= resp_byte;
         load_pend <= 1'b0;
      end else if (byte_done) begin
         load_pend <= 1'b1;
      end else if (sck_fall && !cs_s) begin
         tx_shift  <= load_pend ? resp_byte : {tx_shift[6:0], 1'b0};
         load_pend <= 1'b0;
      end
   end

   assign miso = tx_shift[7];

   // a byte can only complete inside a frame
   byte_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
      byte_done |-> !cs_s)
      else $error("byte_done while cs_n high");

endmodule

`default_nettype wire

/* cmd_frame_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module cmd_frame_fsm (
   input  wire logic                clk,
   input  wire logic                arst_n,
   input  wire logic                cs_n,
   input  wire logic                frame_start,
   input  wire logic                byte_done,
   input  wire logic [7:0]          rx_byte,
   output logic                     cmd_ready,
   output logic                     param_ready,
   output logic [7:0]               cmd_byte,
   output logic [7:0]               param_data,
   output spi_frame_pkg::byte_idx_t byte_idx
);

   typedef enum logic [1:0] {
      IDLE,
      WAIT_CMD,
      WAIT_PARAM
   } state_t;

   state_t                      state;
   logic [`MCU_SYNC_STAGES-1:0] cs_sync;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cs_sync     <= '1;
         state       <= IDLE;
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         cmd_byte    <= '0;
         byte_idx    <= '0;
      end else begin
         cs_sync     <= {cs_sync[`MCU_SYNC_STAGES-2:0], cs_n};
         cmd_ready   <= 1'b0;
         param_ready <= 1'b0;
         if (frame_start) begin
            state    <= WAIT_CMD;
            byte_idx <= '0;
         end else if (cs_sync[`MCU_SYNC_STAGES-1]) begin
            state <= IDLE;
         end else if (byte_done) begin
            case (state)
               WAIT_CMD: begin
                  cmd_byte  <= rx_byte;
                  byte_idx  <= 8'd1;
                  cmd_ready <= 1'b1;
                  state     <= WAIT_PARAM;
               end
               WAIT_PARAM: begin
                  // index stays at 255 on very long frames
                  if (byte_idx != '1) begin
                     byte_idx <= byte_idx + 8'd1;
                  end
                  param_ready <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (byte_done) begin
         param_data <= rx_byte;
      end
   end

   // every received byte lands inside an open frame
   byte_not_idle: assert property (@(posedge clk) disable iff (!arst_n)
      byte_done |-> state != IDLE)
      else $error("byte_done outside a frame");

endmodule

`default_nettype wire

/* addr_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_loader #(
   parameter type field_t = logic [23:0]
) (
   input  wire logic       clk,
   input  wire logic       arst_n,
   input  wire logic       load_first,
   input  wire logic       load_next,
   input  wire logic       inc,
   input  wire logic [7:0] data,
   output field_t          value
);

   // big endian load, upper bits beyond the field width fall off
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         value <= '0;
      end else if (load_first) begin
         value <= field_t'(data);
      end else if (load_next) begin
         value <= field_t'({value, data});
      end else if (inc) begin
         value <= field_t'(value + 1'b1);
      end
   end

endmodule

`default_nettype wire

/* mcu_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module mcu_cmd_regs (
   input  wire logic                     clk,
   input  wire logic                     arst_n,
   input  wire logic                     cmd_ready,
   input  wire logic                     param_ready,
   input  wire logic [7:0]               cmd_byte,
   input  wire logic [7:0]               param_data,
   input  wire spi_frame_pkg::byte_idx_t byte_idx,
   input  wire logic [7:0]               mcu_data_in,
   input  wire mcu_cmd_pkg::freq_t       freq,
   output logic [7:0]                    resp_byte,
   output mcu_cmd_pkg::sram_addr_t       addr_out,
   output mcu_cmd_pkg::dac_addr_t        dac_addr_out,
   output logic [3:0]                    mapper,
   output mcu_cmd_pkg::mask_t            rom_mask_out,
   output mcu_cmd_pkg::mask_t            saveram_mask_out,
   output logic                          mcu_read,
   output logic                          mcu_write,
   output logic [7:0]                    mcu_data_out,
   output logic                          dac_play
);

   localparam int PW = $clog2(`MCU_PULSE_CYCLES + 1);

   mcu_cmd_pkg::opcode_grp_e grp;
   mcu_cmd_pkg::freq_t       freq_lat;
   logic                     strobe;
   logic                     addr_sel;
   logic                     addr_first;
   logic                     addr_next;
   logic                     mask_ld;
   logic                     rd_start;
   logic                     wr_start;
   logic                     rd_active;
   logic                     wr_active;
   logic                     acc_last;
   logic                     inc_pend;
   logic [PW-1:0]            pulse_cnt;

   assign grp        = mcu_cmd_pkg::opcode_grp_e'(cmd_byte[7:4]);
   assign strobe     = cmd_ready | param_ready;
   assign addr_sel   = param_ready && (grp == mcu_cmd_pkg::SET_ADDR);
   assign addr_first = addr_sel && (byte_idx == 8'd2);
   assign addr_next  = addr_sel && (byte_idx > 8'd2);
   assign mask_ld    = param_ready && (byte_idx >= 8'd2) && (byte_idx <= 8'd4);
   assign rd_start   = strobe && (grp == mcu_cmd_pkg::READ);
   assign wr_start   = param_ready && (grp == mcu_cmd_pkg::WRITE);
   assign acc_last   = (rd_active | wr_active) && (pulse_cnt == '0);

   //////////////////////////////////////////////////
   // address registers
   //////////////////////////////////////////////////

   // bit 0 of the command picks the DAC address
   addr_loader #(.field_t(mcu_cmd_pkg::sram_addr_t)) u_sram_addr (
      .clk        (clk),
      .arst_n     (arst_n),
      .load_first (addr_first & ~cmd_byte[0]),
      .load_next  (addr_next & ~cmd_byte[0]),
      .inc        (inc_pend),
      .data       (param_data),
      .value      (addr_out)
   );

   addr_loader #(.field_t(mcu_cmd_pkg::dac_addr_t)) u_dac_addr (
      .clk        (clk),
      .arst_n     (arst_n),
      .load_first (addr_first & cmd_byte[0]),
      .load_next  (addr_next & cmd_byte[0]),
      .inc        (1'b0),
      .data       (param_data),
      .value      (dac_addr_out)
   );

   //////////////////////////////////////////////////
   // configuration
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mapper           <= '0;
         rom_mask_out     <= '0;
         saveram_mask_out <= '0;
         dac_play         <= 1'b0;
      end else begin
         if (cmd_ready && grp == mcu_cmd_pkg::MAPPER) begin
            mapper <= cmd_byte[3:0];
         end
         // masks arrive MSB first
         if (mask_ld && grp == mcu_cmd_pkg::ROM_MASK) begin
            rom_mask_out <= {rom_mask_out[15:0], param_data};
         end
         if (mask_ld && grp == mcu_cmd_pkg::SRAM_MASK) begin
            saveram_mask_out <= {saveram_mask_out[15:0], param_data};
         end
         if (cmd_ready && grp == mcu_cmd_pkg::DAC_CTRL) begin
            if (cmd_byte == mcu_cmd_pkg::CMD_DAC_PAUSE) begin
               dac_play <= 1'b0;
            end else if (cmd_byte == mcu_cmd_pkg::CMD_DAC_PLAY) begin
               dac_play <= 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // SRAM access sequencer
   //////////////////////////////////////////////////

   // strobe, low pulse, then optional address increment
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_active <= 1'b0;
         wr_active <= 1'b0;
         pulse_cnt <= '0;
         inc_pend  <= 1'b0;
      end else begin
         inc_pend <= acc_last & cmd_byte[0];
         if (rd_start || wr_start) begin
            rd_active <= rd_start;
            wr_active <= wr_start;
            pulse_cnt <= PW'(`MCU_PULSE_CYCLES - 1);
         end else if (acc_last) begin
            rd_active <= 1'b0;
            wr_active <= 1'b0;
         end else if (rd_active || wr_active) begin
            pulse_cnt <= pulse_cnt - 1'b1;
         end
      end
   end

   assign mcu_read  = ~rd_active;
   assign mcu_write = ~wr_active;

   always_ff @(posedge clk) begin
      if (wr_start) begin
         mcu_data_out <= param_data;
      end
      if (cmd_ready && cmd_byte == mcu_cmd_pkg::CMD_FREQ) begin
         freq_lat <= freq;
      end
   end

   //////////////////////////////////////////////////
   // response byte
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         resp_byte <= '0;
      end else if (acc_last && rd_active) begin
         resp_byte <= mcu_data_in;
      end else if (strobe && grp != mcu_cmd_pkg::READ) begin
         case (cmd_byte)
            mcu_cmd_pkg::CMD_ID: resp_byte <= mcu_cmd_pkg::RESP_ECHO_ID;
            mcu_cmd_pkg::CMD_FREQ: begin
               // first byte straight from the meter, rest from the snapshot
               case (byte_idx)
                  8'd1:    resp_byte <= freq[31:24];
                  8'd2:    resp_byte <= freq_lat[23:16];
                  8'd3:    resp_byte <= freq_lat[15:8];
                  8'd4:    resp_byte <= freq_lat[7:0];
                  default: resp_byte <= 8'h00;
               endcase
            end
            // echo of the byte just received
            default: resp_byte <= cmd_ready ? cmd_byte : param_data;
         endcase
      end
   end

   // each access and its increment end before the next byte strobe
   acc_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
      (rd_start || wr_start) |-> !(rd_active || wr_active || inc_pend))
      else $error("SRAM access started while the previous one was running");

endmodule

`default_nettype wire

/* clk_freq_meter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module clk_freq_meter (
   input  wire logic          clk,
   input  wire logic          arst_n,
   input  wire logic          sysclk,
   output mcu_cmd_pkg::freq_t freq
);

   localparam int GW = $clog2(`MCU_FREQ_GATE_CYCLES);

   logic [`MCU_SYNC_STAGES-1:0] sys_sync;
   logic                        sys_d;
   logic                        sys_rise;
   logic [GW-1:0]               gate_cnt;
   mcu_cmd_pkg::freq_t          edge_cnt;

   assign sys_rise = sys_sync[`MCU_SYNC_STAGES-1] & ~sys_d;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sys_sync <= '0;
         sys_d    <= 1'b0;
         gate_cnt <= '0;
         edge_cnt <= '0;
         freq     <= '0;
      end else begin
         sys_sync <= {sys_sync[`MCU_SYNC_STAGES-2:0], sysclk};
         sys_d    <= sys_sync[`MCU_SYNC_STAGES-1];
         // end of window, edge in the last cycle still counts
         if (gate_cnt == GW'(`MCU_FREQ_GATE_CYCLES - 1)) begin
            gate_cnt <= '0;
            freq     <= edge_cnt + 32'(sys_rise);
            edge_cnt <= '0;
         end else begin
            gate_cnt <= gate_cnt + 1'b1;
            edge_cnt <= edge_cnt + 32'(sys_rise);
         end
      end
   end

endmodule

`default_nettype wire

/* mcu_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd_top (
   input  wire logic               clk,
   input  wire logic               arst_n,
   input  wire logic               sck,
   input  wire logic               mosi,
   input  wire logic               cs_n,
   input  wire logic [7:0]         mcu_data_in,
   input  wire logic               sysclk,
   output logic                    miso,
   output mcu_cmd_pkg::sram_addr_t addr_out,
   output mcu_cmd_pkg::dac_addr_t  dac_addr_out,
   output logic [3:0]              mapper,
   output mcu_cmd_pkg::mask_t      rom_mask_out,
   output mcu_cmd_pkg::mask_t      saveram_mask_out,
   output logic                    mcu_read,
   output logic                    mcu_write,
   output logic [7:0]              mcu_data_out,
   output logic                    dac_play
);

   logic                     frame_start;
   logic                     byte_done;
   logic [7:0]               rx_byte;
   logic                     cmd_ready;
   logic                     param_ready;
   logic [7:0]               cmd_byte;
   logic [7:0]               param_data;
   spi_frame_pkg::byte_idx_t byte_idx;
   logic [7:0]               resp_byte;
   mcu_cmd_pkg::freq_t       freq;

   spi_byte_rx u_spi_rx (
      .clk         (clk),
      .arst_n      (arst_n),
      .sck         (sck),
      .mosi        (mosi),
      .cs_n        (cs_n),
      .resp_byte   (resp_byte),
      .miso        (miso),
      .frame_start (frame_start),
      .byte_done   (byte_done),
      .rx_byte     (rx_byte),
      .bit_cnt     ()
   );

   cmd_frame_fsm u_frame (
      .clk         (clk),
      .arst_n      (arst_n),
      .cs_n        (cs_n),
      .frame_start (frame_start),
      .byte_done   (byte_done),
      .rx_byte     (rx_byte),
      .cmd_ready   (cmd_ready),
      .param_ready (param_ready),
      .cmd_byte    (cmd_byte),
      .param_data  (param_data),
      .byte_idx    (byte_idx)
   );

   mcu_cmd_regs u_regs (
      .clk              (clk),
      .arst_n           (arst_n),
      .cmd_ready        (cmd_ready),
      .param_ready      (param_ready),
      .cmd_byte         (cmd_byte),
      .param_data       (param_data),
      .byte_idx         (byte_idx),
      .mcu_data_in      (mcu_data_in),
      .freq             (freq),
      .resp_byte        (resp_byte),
      .addr_out         (addr_out),
      .dac_addr_out     (dac_addr_out),
      .mapper           (mapper),
      .rom_mask_out     (rom_mask_out),
      .saveram_mask_out (saveram_mask_out),
      .mcu_read         (mcu_read),
      .mcu_write        (mcu_write),
      .mcu_data_out     (mcu_data_out),
      .dac_play         (dac_play)
   );

   clk_freq_meter u_freq (
      .clk    (clk),
      .arst_n (arst_n),
      .sysclk (sysclk),
      .freq   (freq)
   );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset let go on a falling edge, clear of the sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tb_mcu_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mcu_macros.svh"

module tb_mcu_cmd;

   // sck half period in clk cycles
   localparam int HALF_SCK = 8;
   // frame traffic is roughly 6500 cycles, limit well above it
   localparam int TIMEOUT_CYCLES = 40000;
   localparam logic [23:0] ADDR_A = 24'h0A1B3C;

   logic                    clk;
   logic                    arst_n;
   logic                    sck;
   logic                    mosi;
   logic                    cs_n;
   logic                    sysclk;
   logic [7:0]              mcu_data_in;
   logic                    miso;
   mcu_cmd_pkg::sram_addr_t addr_out;
   mcu_cmd_pkg::dac_addr_t  dac_addr_out;
   logic [3:0]              mapper;
   mcu_cmd_pkg::mask_t      rom_mask_out;
   mcu_cmd_pkg::mask_t      saveram_mask_out;
   logic                    mcu_read;
   logic                    mcu_write;
   logic [7:0]              mcu_data_out;
   logic                    dac_play;

   logic [7:0] sram [0:255];
   logic [7:0] tx_buf [0:15];
   logic [7:0] rx_buf [0:15];
   integer     seed;
   int         cycle_cnt = 0;
   int         check_cnt = 0;
   int         error_cnt = 0;
   int         read_low_cnt = 0;

   tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clk_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   mcu_cmd_top uut (
      .clk              (clk),
      .arst_n           (arst_n),
      .sck              (sck),
      .mosi             (mosi),
      .cs_n             (cs_n),
      .mcu_data_in      (mcu_data_in),
      .sysclk           (sysclk),
      .miso             (miso),
      .addr_out         (addr_out),
      .dac_addr_out     (dac_addr_out),
      .mapper           (mapper),
      .rom_mask_out     (rom_mask_out),
      .saveram_mask_out (saveram_mask_out),
      .mcu_read         (mcu_read),
      .mcu_write        (mcu_write),
      .mcu_data_out     (mcu_data_out),
      .dac_play         (dac_play)
   );

   //////////////////////////////////////////////////
   // SRAM model, console clock, watchdog
   //////////////////////////////////////////////////

   assign mcu_data_in = sram[addr_out[7:0]];

   // write lands when the strobe goes back high
   always @(posedge mcu_write) begin
      if (arst_n === 1'b1) begin
         sram[addr_out[7:0]] = mcu_data_out;
      end
   end

   always #175 sysclk = ~sysclk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   always @(negedge clk) begin
      if (mcu_read === 1'b0) begin
         read_low_cnt <= read_low_cnt + 1;
      end
   end

   initial begin : watchdog
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout: tests still running after %0d clk cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // SPI master and checks
   //////////////////////////////////////////////////

   // mode 0, MSB first, miso sampled right before each rising sck
   task automatic shift_frame(input int nbytes);
      int b;
      int k;
      @(negedge clk);
      cs_n = 1'b0;
      repeat (HALF_SCK) @(negedge clk);
      for (b = 0; b < nbytes; b++) begin
         for (k = 7; k >= 0; k--) begin
            sck  = 1'b0;
            mosi = tx_buf[b][k];
            repeat (HALF_SCK) @(negedge clk);
            rx_buf[b][k] = miso;
            sck = 1'b1;
            repeat (HALF_SCK) @(negedge clk);
         end
      end
      sck = 1'b0;
      repeat (HALF_SCK) @(negedge clk);
      cs_n = 1'b1;
      repeat (2 * HALF_SCK) @(negedge clk);
   endtask

   // command byte, then nparams bytes taken MSB first from params
   task automatic send_cmd(input logic [7:0] cmd, input logic [31:0] params,
                           input int nparams);
      int i;
      tx_buf[0] = cmd;
      for (i = 0; i < nparams; i++) begin
         tx_buf[i + 1] = params[8 * (nparams - 1 - i) +: 8];
      end
      shift_frame(nparams + 1);
   endtask

   task automatic check_eq(input string test_name, input logic [31:0] actual,
                           input logic [31:0] expected);
      check_cnt++;
      assert (actual === expected)
         else begin
            error_cnt++;
            $display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
         end
   endtask

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic reset_defaults();
      check_eq("reset mcu_read", 32'(mcu_read), 32'h1);
      check_eq("reset mcu_write", 32'(mcu_write), 32'h1);
      check_eq("reset dac_play", 32'(dac_play), 32'h0);
      check_eq("reset miso", 32'(miso), 32'h0);
      check_eq("reset addr_out", 32'(addr_out), 32'h0);
      check_eq("reset mapper", 32'(mapper), 32'h0);
      check_eq("reset rom_mask", 32'(rom_mask_out), 32'h0);
   endtask

   task automatic config_regs();
      send_cmd(8'h37, 32'h0, 0);
      check_eq("mapper", 32'(mapper), 32'h7);
      send_cmd(8'h10, 32'h003CA571, 3);
      check_eq("rom_mask", 32'(rom_mask_out), 32'h003CA571);
      send_cmd(8'h20, 32'h000FE012, 3);
      check_eq("saveram_mask", 32'(saveram_mask_out), 32'h000FE012);
   endtask

   task automatic addr_load();
      logic [15:0] dac_word;
      dac_word = 16'hD69B;
      send_cmd(8'h00, 32'h00C0FFEE, 3);
      check_eq("sram addr", 32'(addr_out), 32'h00C0FFEE);
      send_cmd(8'h01, 32'(dac_word), 2);
      check_eq("dac addr", 32'(dac_addr_out), 32'(dac_word[10:0]));
   endtask

   task automatic write_burst();
      logic [31:0] data_word;
      logic [7:0]  idx;
      int          reads_before;
      int          i;
      data_word = 32'hC35A0FE7;
      send_cmd(8'h00, {8'h00, ADDR_A}, 3);
      reads_before = read_low_cnt;
      send_cmd(8'h91, data_word, 4);
      for (i = 0; i < 4; i++) begin
         idx = ADDR_A[7:0] + 8'(i);
         check_eq("write data", 32'(sram[idx]), 32'(data_word[8 * (3 - i) +: 8]));
      end
      check_eq("write end addr", 32'(addr_out), 32'(ADDR_A + 24'd4));
      check_cnt++;
      assert (read_low_cnt == reads_before)
         else begin
            error_cnt++;
            $display("mcu_read went low during the write frame");
         end
   endtask

   task automatic read_burst();
      mcu_cmd_pkg::sram_addr_t addr_b;
      logic [7:0]              idx;
      int                      i;
      // two random cells, then two written ones
      addr_b = ADDR_A - 24'd2;
      send_cmd(8'h00, {8'h00, addr_b}, 3);
      send_cmd(8'h81, 32'h0, 4);
      for (i = 0; i < 4; i++) begin
         idx = addr_b[7:0] + 8'(i);
         check_eq("read data", 32'(rx_buf[i + 1]), 32'(sram[idx]));
      end
   endtask

   task automatic id_echo_dac();
      send_cmd(8'hF0, 32'h0, 1);
      check_eq("id", 32'(rx_buf[1]), 32'h000000A5);
      send_cmd(8'h55, 32'h00001234, 2);
      check_eq("echo cmd", 32'(rx_buf[1]), 32'h00000055);
      check_eq("echo param", 32'(rx_buf[2]), 32'h00000012);
      send_cmd(8'hE2, 32'h0, 0);
      check_eq("dac play", 32'(dac_play), 32'h1);
      send_cmd(8'hE1, 32'h0, 0);
      check_eq("dac pause", 32'(dac_play), 32'h0);
   endtask

   task automatic freq_readback();
      logic [31:0] measured;
      int          lo;
      // edges of a 350 ns clock inside one gate of 100 ns cycles
      lo = (`MCU_FREQ_GATE_CYCLES * 100) / 350;
      wait (cycle_cnt >= 2 * `MCU_FREQ_GATE_CYCLES + 50);
      @(negedge clk);
      send_cmd(8'hFE, 32'h0, 4);
      measured = {rx_buf[1], rx_buf[2], rx_buf[3], rx_buf[4]};
      check_cnt++;
      assert (measured >= 32'(lo) && measured <= 32'(lo + 1))
         else begin
            error_cnt++;
            $display("[FAIL] freq: expected %0d or %0d, actual %0d", lo, lo + 1, measured);
         end
   endtask

   initial begin : main
      int          i;
      logic [31:0] rnd;
      sck    = 1'b0;
      mosi   = 1'b0;
      cs_n   = 1'b1;
      sysclk = 1'b0;
      seed   = 32'hcf9b;
      for (i = 0; i < 256; i++) begin
         rnd     = $random(seed);
         sram[i] = rnd[7:0];
      end
      wait (arst_n === 1'b1);
      repeat (2) @(negedge clk);
      reset_defaults();
      config_regs();
      addr_load();
      write_burst();
      read_burst();
      id_echo_dac();
      freq_readback();
      $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
spi_frame_pkg.sv
mcu_cmd_pkg.sv
spi_byte_rx.sv
cmd_frame_fsm.sv
addr_loader.sv
mcu_cmd_regs.sv
clk_freq_meter.sv
mcu_cmd_top.sv
tb_clk_gen.sv
tb_mcu_cmd.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_mcu_cmd -f project.f -o tb_mcu_cmd_sim
output=$(./obj_dir/tb_mcu_cmd_sim 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'Test OK'; then
   exit 0
fi
exit 1
